// ==== verilog/acc_params.svh ====
`ifndef ACC_PARAMS_SVH
`define ACC_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// widths of the operand path
////////////////////////////////////////////////////////////////////////////

// one tag per reorder-buffer slot, sixteen slots.
`define ACC_TAG_W 4

// single-precision operand.
`define ACC_DATA_W 32

// up to seven unresolved branches may sit ahead of an operand.
`define ACC_BCOUNT_W 3

`endif

// ==== verilog/acc_pkg.sv ====
`include "acc_params.svh"

package acc_pkg;

	typedef logic [`ACC_TAG_W-1:0] tag_t;
	typedef logic [`ACC_DATA_W-1:0] data_t;
	typedef logic [`ACC_BCOUNT_W-1:0] bcount_t;

	////////////////////////////////////////////////////////////////////////////
	// records
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic ready;       // data is valid; otherwise tag names the producer.
		tag_t tag;
		data_t data;
	} opd_t;

	typedef struct packed {
		opd_t opd;
		bcount_t bcount;   // older branches still unresolved at issue.
	} issue_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		data_t data;
	} cdb_t;

	// shared by both four-phase handshake FSMs.
	typedef enum logic [1:0] {
		idle,
		busy,
		wait_release
	} hs_state_t;

endpackage

// ==== verilog/issue_receiver.sv ====
module issue_receiver (
	input logic clk,
	input logic rst_n,
	input logic issue_req,
	input acc_pkg::issue_t issue,
	output logic issue_ack,
	output logic new_valid,
	output acc_pkg::issue_t new_issue,
	input logic new_ready
);
	import acc_pkg::*;

	hs_state_t state;

	////////////////////////////////////////////////////////////////////////////
	// four-phase handshake toward the issuer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			issue_ack <= 1'b0;
			new_valid <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (issue_req) begin
						new_valid <= 1'b1;     // offer the record next cycle.
						state <= busy;
					end
				end
				busy: begin
					if (new_valid && new_ready) begin
						new_valid <= 1'b0;
						issue_ack <= 1'b1;     // the station holds the record now.
						state <= wait_release;
					end
				end
				wait_release: begin
					if (!issue_req) begin
						issue_ack <= 1'b0;
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// the issuer keeps the record stable only while req is high, so take a copy.
	always_ff @(posedge clk) begin
		if (state == idle && issue_req) begin
			new_issue <= issue;
		end
	end

endmodule

// ==== verilog/operand_station.sv ====
module operand_station (
	input logic clk,
	input logic rst_n,
	input logic new_valid,
	input acc_pkg::issue_t new_issue,
	output logic new_ready,
	input acc_pkg::cdb_t result,
	input logic branch_commit,
	input logic failure,
	output logic out_valid,
	output acc_pkg::data_t out_data,
	input logic out_ready
);
	import acc_pkg::*;

	logic e_valid;
	opd_t e_opd;
	bcount_t e_bcount;

	logic confirmed;
	logic dispatch;
	logic load;
	logic sel_valid;
	opd_t sel_opd;
	bcount_t sel_bcount;
	logic hit;
	logic kill;
	opd_t nxt_opd;
	bcount_t nxt_bcount;

	////////////////////////////////////////////////////////////////////////////
	// handoff on both sides
	////////////////////////////////////////////////////////////////////////////

	assign confirmed = e_valid && (e_bcount == '0);   // no older branch can kill it.
	assign out_valid = confirmed && e_opd.ready;
	assign out_data = e_opd.data;
	assign dispatch = out_valid && out_ready;

	// an entry leaving this cycle counts as empty, so a new one can follow at once.
	assign new_ready = !e_valid || dispatch;
	assign load = new_valid && new_ready;

	////////////////////////////////////////////////////////////////////////////
	// next entry
	////////////////////////////////////////////////////////////////////////////

	// the entry that lives through this cycle: the incoming one or the held one.
	always_comb begin
		if (load) begin
			sel_opd = new_issue.opd;
			sel_bcount = new_issue.bcount;
		end else begin
			sel_opd = e_opd;
			sel_bcount = e_bcount;
		end
	end

	assign sel_valid = load || (e_valid && !dispatch);

	// a broadcast in the load cycle must wake the entry too.
	assign hit = result.valid && !sel_opd.ready && (result.tag == sel_opd.tag);

	always_comb begin
		nxt_opd.ready = sel_opd.ready || hit;
		nxt_opd.tag = sel_opd.tag;
		nxt_opd.data = hit ? result.data : sel_opd.data;
	end

	assign nxt_bcount = (branch_commit && sel_bcount != '0) ? sel_bcount - 1'b1 : sel_bcount;

	// Confirmed entries are not on the wrong path and survive the flush.
	assign kill = failure && (sel_bcount != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_valid <= 1'b0;
		end else begin
			e_valid <= sel_valid && !kill;
		end
	end

	always_ff @(posedge clk) begin
		e_opd <= nxt_opd;           // only meaningful while e_valid is set.
		e_bcount <= nxt_bcount;
	end

endmodule

// ==== verilog/dispatch_sender.sv ====
module dispatch_sender (
	input logic clk,
	input logic rst_n,
	input logic out_valid,
	input acc_pkg::data_t out_data,
	output logic out_ready,
	output logic acc_req,
	output acc_pkg::data_t acc_data,
	input logic acc_ack
);
	import acc_pkg::*;

	hs_state_t state;
	logic take;

	assign out_ready = (state == idle);
	assign take = out_valid && out_ready;

	////////////////////////////////////////////////////////////////////////////
	// four-phase handshake toward the accumulator
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			acc_req <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (take) begin
						acc_req <= 1'b1;
						state <= busy;
					end
				end
				busy: begin
					if (acc_ack) begin
						acc_req <= 1'b0;
						state <= wait_release;
					end
				end
				wait_release: begin
					if (!acc_ack) begin
						state <= idle;       // ack released, the next operand may come.
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// written only at a transfer, so acc_data holds until the ack is released.
	always_ff @(posedge clk) begin
		if (take) begin
			acc_data <= out_data;
		end
	end

endmodule

// ==== verilog/acc_operand_path.sv ====
module acc_operand_path (
	input logic clk,
	input logic rst_n,
	input logic issue_req,
	input acc_pkg::issue_t issue,
	output logic issue_ack,
	input acc_pkg::cdb_t result,
	input logic branch_commit,
	input logic failure,
	output logic acc_req,
	output acc_pkg::data_t acc_data,
	input logic acc_ack
);
	import acc_pkg::*;

	logic new_valid;
	issue_t new_issue;
	logic new_ready;
	logic out_valid;
	data_t out_data;
	logic out_ready;

	issue_receiver u_receiver (
		.clk(clk),
		.rst_n(rst_n),
		.issue_req(issue_req),
		.issue(issue),
		.issue_ack(issue_ack),
		.new_valid(new_valid),
		.new_issue(new_issue),
		.new_ready(new_ready)
	);

	operand_station u_station (
		.clk(clk),
		.rst_n(rst_n),
		.new_valid(new_valid),
		.new_issue(new_issue),
		.new_ready(new_ready),
		.result(result),
		.branch_commit(branch_commit),
		.failure(failure),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_ready(out_ready)
	);

	dispatch_sender u_sender (
		.clk(clk),
		.rst_n(rst_n),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_ready(out_ready),
		.acc_req(acc_req),
		.acc_data(acc_data),
		.acc_ack(acc_ack)
	);

endmodule

// ==== bench/acc_tb.sv ====
module acc_tb;
	import acc_pkg::*;

	localparam int NUM_ROWS = 12;
	localparam int TIMEOUT = NUM_ROWS * 60;
	localparam int DRAIN_LIMIT = 200;

	typedef struct packed {
		data_t data;
		tag_t tag;
		logic ready;
		bcount_t bcount;
		logic bc_en;             // send a broadcast with bc_tag and bc_data.
		logic bc_early;          // put it on the bus in the cycle the entry loads.
		tag_t bc_tag;
		data_t bc_data;
		logic [3:0] n_wrong;     // other-tag broadcasts sent before it.
		logic [3:0] n_commit;
		logic fail_en;
		logic [3:0] fail_at;     // commits already sent when failure pulses.
		logic drain;             // wait for every earlier output before issuing.
	} row_t;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic issue_req = 1'b0;
	issue_t issue = '0;
	logic issue_ack;
	cdb_t result = '0;
	logic branch_commit = 1'b0;
	logic failure = 1'b0;
	logic acc_req;
	data_t acc_data;
	logic acc_ack = 1'b0;

	row_t rows [NUM_ROWS];
	data_t exp_data [$];
	int exp_row [$];
	int released = -1;           // newest row whose output may legally appear.
	int seed = 43;
	int cycles = 0;

	always #2 clk = ~clk;

	acc_operand_path DUT (
		.clk(clk),
		.rst_n(rst_n),
		.issue_req(issue_req),
		.issue(issue),
		.issue_ack(issue_ack),
		.result(result),
		.branch_commit(branch_commit),
		.failure(failure),
		.acc_req(acc_req),
		.acc_data(acc_data),
		.acc_ack(acc_ack)
	);

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			fail_now($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic check_none(input logic req, input string what);
		if (req !== 1'b0) begin
			fail_now($sformatf("unexpected acc_req: %s", what));
		end
	endtask

	task automatic check_ack(input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("ERR issue_ack got 0x%0h expected 0x%0h", got, exp));
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			fail_now("timeout: the run did not finish within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	// data, tag, ready, bcount, then bc_en, bc_early, bc_tag, bc_data, n_wrong,
	// n_commit, fail_en, fail_at, drain.
	task automatic fill_table();
		rows[0] = '{32'h3f800000, 4'h1, 1'b1, 3'd0,
			1'b0, 1'b0, 4'h0, 32'h0, 4'd0, 4'd0, 1'b0, 4'd0, 1'b0};
		rows[1] = '{32'h40490fdb, 4'h2, 1'b1, 3'd0,
			1'b0, 1'b0, 4'h0, 32'h0, 4'd0, 4'd0, 1'b0, 4'd0, 1'b0};
		rows[2] = '{32'h0, 4'h5, 1'b0, 3'd0,
			1'b1, 1'b0, 4'h5, 32'h41200000, 4'd3, 4'd0, 1'b0, 4'd0, 1'b0};
		rows[3] = '{32'h0, 4'h9, 1'b0, 3'd0,
			1'b1, 1'b1, 4'h9, 32'hc0a00000, 4'd0, 4'd0, 1'b0, 4'd0, 1'b1};
		rows[4] = '{32'h3e800000, 4'h2, 1'b1, 3'd3,
			1'b0, 1'b0, 4'h0, 32'h0, 4'd0, 4'd3, 1'b0, 4'd0, 1'b0};
		rows[5] = '{32'hdeadbeef, 4'h3, 1'b1, 3'd2,
			1'b0, 1'b0, 4'h0, 32'h0, 4'd0, 4'd2, 1'b1, 4'd1, 1'b0};
		rows[6] = '{32'h42c80000, 4'h4, 1'b1, 3'd0,
			1'b0, 1'b0, 4'h0, 32'h0, 4'd0, 4'd0, 1'b0, 4'd0, 1'b0};
		rows[7] = '{32'h0, 4'h6, 1'b0, 3'd1,
			1'b1, 1'b0, 4'h6, 32'h3fc00000, 4'd0, 4'd1, 1'b1, 4'd1, 1'b0};
		rows[8] = '{32'h12345678, 4'h7, 1'b1, 3'd0,
			1'b1, 1'b1, 4'h7, 32'h0badf00d, 4'd0, 4'd0, 1'b0, 4'd0, 1'b1};
		rows[9] = '{32'h0, 4'ha, 1'b0, 3'd2,
			1'b1, 1'b0, 4'ha, 32'h449a4000, 4'd1, 4'd2, 1'b0, 4'd0, 1'b0};
		rows[10] = '{32'h0, 4'hb, 1'b0, 3'd1,
			1'b1, 1'b0, 4'hb, 32'hbf000000, 4'd0, 4'd1, 1'b1, 4'd0, 1'b0};
		rows[11] = '{32'h7f7fffff, 4'hc, 1'b1, 3'd0,
			1'b0, 1'b0, 4'h0, 32'h0, 4'd0, 4'd0, 1'b0, 4'd0, 1'b0};
	endtask

	// a failure before the count reaches zero flushes the entry.
	function automatic logic row_outputs(input row_t rw);
		return !(rw.fail_en && int'(rw.fail_at) < int'(rw.bcount));
	endfunction

	function automatic data_t row_value(input row_t rw);
		if (rw.ready) begin
			return rw.data;
		end
		return rw.bc_data;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// issue side and station inputs
	////////////////////////////////////////////////////////////////////////////

	task automatic pulse_result(input tag_t tag, input data_t data);
		@(posedge clk);
		result <= '{1'b1, tag, data};
		@(posedge clk);
		result <= '0;
	endtask

	task automatic pulse_commit();
		@(posedge clk);
		branch_commit <= 1'b1;
		@(posedge clk);
		branch_commit <= 1'b0;
	endtask

	task automatic pulse_failure();
		@(posedge clk);
		failure <= 1'b1;
		@(posedge clk);
		failure <= 1'b0;
	endtask

	task automatic wait_ack(input logic level);
		while (issue_ack !== level) begin
			@(posedge clk);
		end
	endtask

	task automatic wait_drained();
		while (exp_data.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic send_issue(input row_t rw);
		@(posedge clk);
		issue_req <= 1'b1;
		issue <= '{'{rw.ready, rw.tag, rw.data}, rw.bcount};
		@(posedge clk);
		if (rw.bc_en && rw.bc_early) begin
			result <= '{1'b1, rw.bc_tag, rw.bc_data};   // on the bus in the load cycle.
		end
		@(posedge clk);
		result <= '0;
		wait_ack(1'b1);
		issue_req <= 1'b0;
		@(posedge clk);
		check_ack(issue_ack, 1'b1);   // the receiver sees req low at this edge.
		@(posedge clk);
		check_ack(issue_ack, 1'b0);
	endtask

	task automatic apply_row(input int r);
		row_t rw;
		int k;
		rw = rows[r];
		if (rw.drain) begin
			wait_drained();
		end
		if (row_outputs(rw)) begin
			exp_data.push_back(row_value(rw));
			exp_row.push_back(r);
		end
		// nothing gates this output once the entry has loaded.
		if ((rw.ready || rw.bc_early) && rw.bcount == '0) begin
			released = r;
		end
		send_issue(rw);
		for (k = 0; k < int'(rw.n_wrong); k++) begin
			pulse_result(rw.bc_tag ^ tag_t'(k + 1), data_t'($random(seed)));
		end
		for (k = 0; k < int'(rw.n_commit); k++) begin
			if (rw.fail_en && k == int'(rw.fail_at)) begin
				pulse_failure();
			end
			pulse_commit();
		end
		if (rw.fail_en && int'(rw.fail_at) >= int'(rw.n_commit)) begin
			pulse_failure();
		end
		if (rw.bc_en && !rw.bc_early) begin
			pulse_result(rw.bc_tag, rw.bc_data);
		end
		@(posedge clk);
		released = r;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// accumulator side
	////////////////////////////////////////////////////////////////////////////

	task automatic take_output();
		int delay;
		data_t held;
		if (exp_data.size() == 0) begin
			check_none(acc_req, "an output arrived with none pending");
		end
		if (exp_row[0] > released) begin
			fail_now($sformatf("acc_req rose for row %0d before its inputs were sent",
				exp_row[0]));
		end
		check_data("acc_data", acc_data, exp_data[0]);
		held = exp_data.pop_front();
		void'(exp_row.pop_front());
		delay = $unsigned($random(seed)) % 6;
		repeat (delay) begin
			@(posedge clk);
			check_data("acc_data", acc_data, held);
		end
		acc_ack <= 1'b1;
		do begin
			@(posedge clk);
			check_data("acc_data", acc_data, held);   // held until the ack is seen.
		end while (acc_req);
		acc_ack <= 1'b0;
	endtask

	initial begin : acc_responder
		forever begin
			@(posedge clk);
			if (acc_req) begin
				take_output();
			end
		end
	end

	initial begin : run_table
		int r;
		int k;
		fill_table();
		repeat (3) @(posedge clk);
		check_ack(issue_ack, 1'b0);
		check_none(acc_req, "high while in reset");
		rst_n <= 1'b1;
		for (r = 0; r < NUM_ROWS; r++) begin
			apply_row(r);
		end
		for (k = 0; k < DRAIN_LIMIT && exp_data.size() != 0; k++) begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk);   // a late extra output is caught by the responder.
		if (exp_data.size() != 0) begin
			fail_now($sformatf("missing acc_req: %0d expected outputs never arrived",
				exp_data.size()));
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/acc_pkg.sv
verilog/issue_receiver.sv
verilog/operand_station.sv
verilog/dispatch_sender.sv
verilog/acc_operand_path.sv
bench/acc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= acc_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary -Wno-fatal
LOG ?= sim.log

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard verilog/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^TB PASSED$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
